// File: hw/shade_consts.svh
`ifndef SHADE_CONSTS_SVH
`define SHADE_CONSTS_SVH

//////////////////////////////////////////////////
// float constants as bit patterns

// 1.0
`define FLOAT_ONE 32'h3F80_0000
// 255.0
`define FLOAT_255 32'h437F_0000

//////////////////////////////////////////////////
// stage latencies in cycles

`define FP_MUL_LATENCY 2
// lookup register, then the multiply
`define SHADE_LATENCY  (1 + `FP_MUL_LATENCY)
`define CLAMP_LATENCY  1
`define TO_INT_LATENCY 1

// shade, clamp, scale by 255, convert
`define PIXEL_LATENCY  (`SHADE_LATENCY + `CLAMP_LATENCY + `FP_MUL_LATENCY + `TO_INT_LATENCY)

`endif

// File: hw/float_pkg.sv
package float_pkg;

    //////////////////////////////////////////////////
    // ieee 754 single precision word

    // field view, msb first as stored
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } float32_fields_t;

    // one word, read raw or by field
    typedef union packed {
        logic [31:0]     bits;
        float32_fields_t f;
    } float32_t;

endpackage

// File: hw/pixel_pkg.sv
package pixel_pkg;

    //////////////////////////////////////////////////
    // colour in float form, r in the top word

    typedef struct packed {
        float_pkg::float32_t r;
        float_pkg::float32_t g;
        float_pkg::float32_t b;
    } float_rgb_t;

    //////////////////////////////////////////////////
    // hit block as delivered by the ray stage

    typedef struct packed {
        logic [2:0] color;
        logic [2:0] dir;
        logic       visible;
    } block_hit_t;

    // screen coordinate of one pixel
    typedef struct packed {
        logic [10:0] x;
        logic [9:0]  y;
    } pixel_pos_t;

    // 4 bit per channel output colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

endpackage

// File: hw/fp_mul.sv
`timescale 1ns/1ns

module fp_mul (
    input  wire                 clk_in,
    input  wire                 rst_in,
    input  wire                 valid_in,
    input  float_pkg::float32_t a,
    input  float_pkg::float32_t b,
    output float_pkg::float32_t result,
    output logic                valid_out
);

    // stage 1 registers
    logic              s1_valid;
    logic              s1_sign;
    logic              s1_zero;
    logic signed [9:0] s1_exp;
    logic [47:0]       s1_prod;

    // stage 2 normalisation
    logic signed [9:0]   norm_exp;
    logic [22:0]         norm_mant;
    float_pkg::float32_t next_result;

    //////////////////////////////////////////////////
    // stage 1: sign, exponent sum, mantissa product

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid <= 1'b0;
            s1_sign  <= 1'b0;
            s1_zero  <= 1'b1;
            s1_exp   <= '0;
            s1_prod  <= '0;
        end else begin
            s1_valid <= valid_in;
            s1_sign  <= a.f.sign ^ b.f.sign;
            // exponent 0 counts as zero, denormals flush
            s1_zero  <= (a.f.exponent == 8'd0) || (b.f.exponent == 8'd0);
            s1_exp   <= $signed({2'b00, a.f.exponent})
                      + $signed({2'b00, b.f.exponent}) - 10'sd127;
            s1_prod  <= {1'b1, a.f.mantissa} * {1'b1, b.f.mantissa};
        end
    end

    //////////////////////////////////////////////////
    // stage 2: one bit normalise, truncate

    always_comb begin
        // product of two 1.x values lies in [1, 4)
        if (s1_prod[47]) begin
            norm_exp  = s1_exp + 10'sd1;
            norm_mant = s1_prod[46:24];
        end else begin
            norm_exp  = s1_exp;
            norm_mant = s1_prod[45:23];
        end

        next_result = '0;
        // underflow goes to zero
        if (!s1_zero && norm_exp > 10'sd0) begin
            next_result.f.sign     = s1_sign;
            next_result.f.exponent = norm_exp[7:0];
            next_result.f.mantissa = norm_mant;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            result    <= '0;
            valid_out <= 1'b0;
        end else begin
            result    <= next_result;
            valid_out <= s1_valid;
        end
    end

endmodule

// File: hw/vec_scale.sv
`timescale 1ns/1ns

module vec_scale (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   valid_in,
    input  pixel_pkg::float_rgb_t v,
    input  pixel_pkg::float_rgb_t k,
    output pixel_pkg::float_rgb_t res,
    output logic                  valid_out
);

    // per lane multiply, lanes run in lock step
    fp_mul r_mul (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .a(v.r),
        .b(k.r),
        .result(res.r),
        .valid_out(valid_out)
    );

    // g and b valids match r
    fp_mul g_mul (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .a(v.g),
        .b(k.g),
        .result(res.g),
        .valid_out()
    );

    fp_mul b_mul (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .a(v.b),
        .b(k.b),
        .result(res.b),
        .valid_out()
    );

endmodule

// File: hw/vec_clamp_one.sv
`timescale 1ns/1ns

`include "shade_consts.svh"

module vec_clamp_one (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   valid_in,
    input  pixel_pkg::float_rgb_t v,
    output pixel_pkg::float_rgb_t res,
    output logic                  valid_out
);

    localparam float_pkg::float32_t float_one = `FLOAT_ONE;

    // min(x, 1.0)
    // for positive floats the {exponent, mantissa} order is the value order
    function automatic float_pkg::float32_t clamp_one(input float_pkg::float32_t x);
        logic above;
        above = !x.f.sign
             && ({x.f.exponent, x.f.mantissa} > {float_one.f.exponent, float_one.f.mantissa});
        clamp_one = above ? float_one : x;
    endfunction

    //////////////////////////////////////////////////
    // compare and select in one register stage

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res       <= '0;
            valid_out <= 1'b0;
        end else begin
            res.r     <= clamp_one(v.r);
            res.g     <= clamp_one(v.g);
            res.b     <= clamp_one(v.b);
            valid_out <= valid_in;
        end
    end

endmodule

// File: hw/fp_to_int.sv
`timescale 1ns/1ns

module fp_to_int (
    input  wire                 clk_in,
    input  wire                 rst_in,
    input  wire                 valid_in,
    input  float_pkg::float32_t a,
    output logic [31:0]         result,
    output logic                valid_out
);

    logic [4:0]  shift;
    logic [54:0] shifted;
    logic [31:0] next_result;

    always_comb begin
        // unbiased exponent, only meaningful for 127..158
        shift   = 5'(a.f.exponent - 8'd127);
        // hidden bit back in, binary point sits above bit 23
        shifted = {31'b0, 1'b1, a.f.mantissa} << shift;

        if (a.f.sign || a.f.exponent < 8'd127) begin
            // negative or below 1
            next_result = '0;
        end else if (a.f.exponent > 8'd158) begin
            // beyond 2^31, saturate
            next_result = '1;
        end else begin
            next_result = shifted[54:23];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            result    <= '0;
            valid_out <= 1'b0;
        end else begin
            result    <= next_result;
            valid_out <= valid_in;
        end
    end

endmodule

// File: hw/pixel_shader.sv
`timescale 1ns/1ns

`include "shade_consts.svh"

module pixel_shader (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   valid_in,
    input  pixel_pkg::block_hit_t hit,
    output pixel_pkg::float_rgb_t color,
    output logic                  valid_out
);

    pixel_pkg::float_rgb_t palette_entry;
    pixel_pkg::float_rgb_t palette_q;
    logic [31:0]           shade_entry;
    pixel_pkg::float_rgb_t shade_q;
    logic                  lookup_valid;

    //////////////////////////////////////////////////
    // palette, components in steps of 1/16

    always_comb begin
        case (hit.color)
            3'd0: palette_entry = {32'h3F00_0000, 32'h3F00_0000, 32'h3F00_0000};
            3'd1: palette_entry = {32'h3F80_0000, 32'h3E00_0000, 32'h3D80_0000};
            3'd2: palette_entry = {32'h3E40_0000, 32'h3F40_0000, 32'h3E80_0000};
            3'd3: palette_entry = {32'h3E00_0000, 32'h3EA0_0000, 32'h3F70_0000};
            // overbright, clamps after shading
            3'd4: palette_entry = {32'h3FC0_0000, 32'h3FA0_0000, 32'h0000_0000};
            3'd5: palette_entry = {32'h3F50_0000, 32'h3EE0_0000, 32'h3F20_0000};
            3'd6: palette_entry = {32'h3F30_0000, 32'h3F10_0000, 32'h3EC0_0000};
            default: palette_entry = {`FLOAT_ONE, `FLOAT_ONE, `FLOAT_ONE};
        endcase
    end

    // face shade by hit direction
    always_comb begin
        case (hit.dir)
            3'd1: shade_entry = 32'h3F00_0000;
            3'd2: shade_entry = 32'h3F40_0000;
            3'd3: shade_entry = 32'h3F40_0000;
            3'd4: shade_entry = 32'h3FA0_0000;
            3'd5: shade_entry = 32'h3FC0_0000;
            // top face and unused codes, unshaded
            default: shade_entry = `FLOAT_ONE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            palette_q    <= '0;
            shade_q      <= '0;
            lookup_valid <= 1'b0;
        end else begin
            palette_q      <= palette_entry;
            shade_q.r.bits <= shade_entry;
            shade_q.g.bits <= shade_entry;
            shade_q.b.bits <= shade_entry;
            lookup_valid   <= valid_in;
        end
    end

    //////////////////////////////////////////////////
    // colour times shade

    vec_scale shade_mul (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(lookup_valid),
        .v(palette_q),
        .k(shade_q),
        .res(color),
        .valid_out(valid_out)
    );

endmodule

// File: hw/pixel_rgb_formatter.sv
`timescale 1ns/1ns

`include "shade_consts.svh"

module pixel_rgb_formatter (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    valid_in,
    input  pixel_pkg::pixel_pos_t  pos_in,
    input  pixel_pkg::block_hit_t  hit_in,
    output pixel_pkg::pixel_pos_t  pos_out,
    output logic                   visible_out,
    output pixel_pkg::rgb4_t       rgb_out,
    output logic                   rgb_valid
);

    // shader output
    pixel_pkg::float_rgb_t base;
    logic                  base_valid;

    // clamped to 1.0
    pixel_pkg::float_rgb_t clamped;
    logic                  clamped_valid;

    // times 255
    pixel_pkg::float_rgb_t scale_k;
    pixel_pkg::float_rgb_t scaled;
    logic                  scaled_valid;

    // integer channels
    logic [31:0] r_int;
    logic [31:0] g_int;
    logic [31:0] b_int;
    logic        r_int_valid;

    // position and visibility alongside the colour
    pixel_pkg::pixel_pos_t     pos_pipe [`PIXEL_LATENCY];
    logic [`PIXEL_LATENCY-1:0] visible_pipe;

    //////////////////////////////////////////////////
    // colour chain

    pixel_shader shader (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .hit(hit_in),
        .color(base),
        .valid_out(base_valid)
    );

    vec_clamp_one clamp (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(base_valid),
        .v(base),
        .res(clamped),
        .valid_out(clamped_valid)
    );

    // uniform scale, same factor on each lane
    assign scale_k.r.bits = `FLOAT_255;
    assign scale_k.g.bits = `FLOAT_255;
    assign scale_k.b.bits = `FLOAT_255;

    vec_scale scale_255 (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(clamped_valid),
        .v(clamped),
        .k(scale_k),
        .res(scaled),
        .valid_out(scaled_valid)
    );

    fp_to_int r_to_int (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(scaled_valid),
        .a(scaled.r),
        .result(r_int),
        .valid_out(r_int_valid)
    );

    fp_to_int g_to_int (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(scaled_valid),
        .a(scaled.g),
        .result(g_int),
        .valid_out()
    );

    fp_to_int b_to_int (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(scaled_valid),
        .a(scaled.b),
        .result(b_int),
        .valid_out()
    );

    //////////////////////////////////////////////////
    // coordinate delay line, same depth as the chain

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `PIXEL_LATENCY; i++) begin
                pos_pipe[i] <= '0;
            end
            visible_pipe <= '0;
        end else begin
            pos_pipe[0] <= pos_in;
            for (int i = 1; i < `PIXEL_LATENCY; i++) begin
                pos_pipe[i] <= pos_pipe[i-1];
            end
            visible_pipe <= {visible_pipe[`PIXEL_LATENCY-2:0], hit_in.visible};
        end
    end

    assign pos_out     = pos_pipe[`PIXEL_LATENCY-1];
    assign visible_out = visible_pipe[`PIXEL_LATENCY-1];

    // top nibble of the 8 bit value
    assign rgb_out.r = r_int[7:4];
    assign rgb_out.g = g_int[7:4];
    assign rgb_out.b = b_int[7:4];
    assign rgb_valid = r_int_valid;

endmodule

// File: dv/pixel_rgb_formatter_props.sv
`timescale 1ns/1ns

`include "shade_consts.svh"

module pixel_rgb_formatter_props (
    input wire                   clk_in,
    input wire                   rst_in,
    input wire                   valid_in,
    input wire                   rgb_valid,
    input wire                   visible_out,
    input pixel_pkg::pixel_pos_t pos_out,
    input pixel_pkg::rgb4_t      rgb_out
);

    // number of failed properties so far
    int fail_count = 0;

    // each accepted item leaves after the full chain
    valid_follows: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_in |-> ##(`PIXEL_LATENCY) rgb_valid
    ) else begin
        $error("rgb_valid missing %0d cycles after valid_in", `PIXEL_LATENCY);
        fail_count++;
    end

    // no output without a matching input
    valid_has_source: assert property (
        @(posedge clk_in) disable iff (rst_in)
        rgb_valid |-> $past(valid_in, `PIXEL_LATENCY)
    ) else begin
        $error("rgb_valid high without valid_in %0d cycles before", `PIXEL_LATENCY);
        fail_count++;
    end

    // synchronous reset clears everything one edge later
    reset_clears: assert property (
        @(posedge clk_in)
        rst_in |=> (!rgb_valid && !visible_out && pos_out == '0 && rgb_out == '0)
    ) else begin
        $error("outputs not zero during reset");
        fail_count++;
    end

endmodule

bind pixel_rgb_formatter pixel_rgb_formatter_props props (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(valid_in),
    .rgb_valid(rgb_valid),
    .visible_out(visible_out),
    .pos_out(pos_out),
    .rgb_out(rgb_out)
);

// File: dv/pixel_rgb_formatter_tb.sv
`timescale 1ns/1ns

module pixel_rgb_formatter_tb;

    localparam int NUM_CASES  = 20;
    localparam int LATENCY    = 7;
    localparam int WAIT_LIMIT = 20;

    logic                  clk_in;
    logic                  rst_in;
    logic                  valid_in;
    pixel_pkg::pixel_pos_t pos_in;
    pixel_pkg::block_hit_t hit_in;
    pixel_pkg::pixel_pos_t pos_out;
    logic                  visible_out;
    pixel_pkg::rgb4_t      rgb_out;
    logic                  rgb_valid;

    // six nibbles per row: color, dir, visible, r, g, b
    logic [3:0] cases [NUM_CASES*6];

    logic [31:0] rng_state;
    int          cycle;
    int          error_count;
    int          test_count;
    int          failed_tests;

    // position and visibility of each item in a burst
    pixel_pkg::pixel_pos_t exp_pos [$];
    logic                  exp_vis [$];

    pixel_rgb_formatter dut (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .pos_in(pos_in),
        .hit_in(hit_in),
        .pos_out(pos_out),
        .visible_out(visible_out),
        .rgb_out(rgb_out),
        .rgb_valid(rgb_valid)
    );

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////
    // stimulus helpers

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic random_pos(output pixel_pkg::pixel_pos_t pos, output logic [1:0] extra);
        rng_state = xorshift(rng_state);
        pos.x     = rng_state[10:0];
        pos.y     = rng_state[25:16];
        extra     = rng_state[30:29];
    endtask

    task automatic drive_row(input int row, input pixel_pkg::pixel_pos_t pos);
        valid_in       = 1'b1;
        pos_in         = pos;
        hit_in.color   = cases[row*6][2:0];
        hit_in.dir     = cases[row*6+1][2:0];
        hit_in.visible = cases[row*6+2][0];
    endtask

    task automatic drive_idle();
        valid_in = 1'b0;
        pos_in   = '0;
        hit_in   = '0;
    endtask

    //////////////////////////////////////////////////
    // checking helpers

    // returns cycles waited, or -1 on timeout
    task automatic wait_rgb_valid(output int waited);
        int i;
        waited = -1;
        i = 0;
        while (waited < 0 && i < WAIT_LIMIT) begin
            @(negedge clk_in);
            i++;
            if (rgb_valid === 1'b1) begin
                waited = i;
            end
        end
        if (waited < 0) begin
            $display("no output arrived within %0d cycles", WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic check_output(input int row, input pixel_pkg::pixel_pos_t pos,
                                input logic vis, input int latency);
        logic [11:0] exp_rgb;
        exp_rgb = {cases[row*6+3], cases[row*6+4], cases[row*6+5]};
        if (latency != LATENCY) begin
            $display("Error: rgb_valid latency expected 0x%0h got 0x%0h (row %0d)",
                     LATENCY, latency, row);
            error_count++;
        end
        if (rgb_out !== exp_rgb) begin
            $display("Error: rgb_out expected 0x%03h got 0x%03h (row %0d)", exp_rgb, rgb_out, row);
            error_count++;
        end
        if (pos_out !== pos) begin
            $display("Error: pos_out expected 0x%06h got 0x%06h (row %0d)", pos, pos_out, row);
            error_count++;
        end
        if (visible_out !== vis) begin
            $display("Error: visible_out expected 0x%0h got 0x%0h (row %0d)",
                     vis, visible_out, row);
            error_count++;
        end
    endtask

    task automatic check_idle_outputs();
        if (rgb_valid !== 1'b0 || visible_out !== 1'b0) begin
            $display("Error: rgb_valid/visible_out expected 0x0/0x0 got 0x%0h/0x%0h",
                     rgb_valid, visible_out);
            error_count++;
        end
        if (pos_out !== '0 || rgb_out !== '0) begin
            $display("Error: pos_out/rgb_out expected 0x0/0x0 got 0x%06h/0x%03h",
                     pos_out, rgb_out);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s finished, no errors", name);
        end else begin
            failed_tests++;
            $display("%s finished with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic run_single(input int row);
        int                    errors_before;
        int                    waited;
        int                    sent;
        logic [1:0]            unused;
        pixel_pkg::pixel_pos_t pos;
        errors_before = error_count;
        random_pos(pos, unused);
        @(negedge clk_in);
        drive_row(row, pos);
        sent = cycle;
        @(negedge clk_in);
        drive_idle();
        wait_rgb_valid(waited);
        if (waited >= 0) begin
            check_output(row, pos, cases[row*6+2][0], cycle - sent);
            @(negedge clk_in);
            if (rgb_valid !== 1'b0) begin
                $display("rgb_valid stayed high after the single output of row %0d", row);
                error_count++;
            end
        end
        finish_test($sformatf("single case %0d", row), errors_before);
    endtask

    // all rows back to back, or with random idle cycles between them
    task automatic run_burst(input string name, input bit with_gaps);
        int                    errors_before;
        int                    waited;
        int                    gaps [NUM_CASES];
        int                    sent_at [NUM_CASES];
        logic [1:0]            gap;
        pixel_pkg::pixel_pos_t pos;
        errors_before = error_count;
        exp_pos.delete();
        exp_vis.delete();
        for (int k = 0; k < NUM_CASES; k++) begin
            random_pos(pos, gap);
            exp_pos.push_back(pos);
            exp_vis.push_back(cases[k*6+2][0]);
            gaps[k] = with_gaps ? int'(gap) : 0;
        end
        fork
            begin
                for (int k = 0; k < NUM_CASES; k++) begin
                    @(negedge clk_in);
                    drive_row(k, exp_pos[k]);
                    sent_at[k] = cycle;
                    for (int g = 0; g < gaps[k]; g++) begin
                        @(negedge clk_in);
                        drive_idle();
                    end
                end
                @(negedge clk_in);
                drive_idle();
            end
            begin
                for (int k = 0; k < NUM_CASES; k++) begin
                    wait_rgb_valid(waited);
                    if (waited >= 0) begin
                        check_output(k, exp_pos[k], exp_vis[k], cycle - sent_at[k]);
                    end
                end
            end
        join
        // pipeline is empty now
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_in);
            if (rgb_valid !== 1'b0) begin
                $display("rgb_valid went high with no item in flight after %s", name);
                error_count++;
            end
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        int errors_before;
        int assert_fails;
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        valid_in     = 1'b0;
        pos_in       = '0;
        hit_in       = '0;
        rng_state    = 32'd39565;
        cycle        = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        $readmemh("dv/pixel_cases.txt", cases);

        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        errors_before = error_count;
        check_idle_outputs();
        @(negedge clk_in);
        check_idle_outputs();
        finish_test("reset outputs", errors_before);

        for (int row = 0; row < NUM_CASES; row++) begin
            run_single(row);
        end
        run_burst("streaming", 1'b0);
        run_burst("gaps", 1'b1);

        assert_fails = dut.props.fail_count;
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 test_count, failed_tests, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/pixel_cases.txt
// columns: color dir visible, then expected r g b nibbles
// one case per row, hex digits
0 0 1 7 7 7
0 1 1 3 3 3
0 5 0 B B B
1 0 1 F 1 0
1 4 1 F 2 1
2 0 1 2 B 3
2 2 0 2 8 2
3 0 1 1 4 E
3 5 1 2 7 F
4 0 1 F F 0
4 1 1 B 9 0
4 3 0 F E 0
5 0 1 C 6 9
5 4 1 F 8 C
5 1 0 6 3 4
6 0 1 A 8 5
6 5 1 F D 8
6 2 1 8 6 4
7 0 1 F F F
7 1 0 7 7 7

// File: project.f
+incdir+hw
hw/float_pkg.sv
hw/pixel_pkg.sv
hw/fp_mul.sv
hw/vec_scale.sv
hw/vec_clamp_one.sv
hw/fp_to_int.sv
hw/pixel_shader.sv
hw/pixel_rgb_formatter.sv
dv/pixel_rgb_formatter_props.sv
dv/pixel_rgb_formatter_tb.sv

// File: Bender.yml
package:
  name: pixel_rgb_formatter

sources:
  - include_dirs:
      - hw
    files:
      - hw/float_pkg.sv
      - hw/pixel_pkg.sv
      - hw/fp_mul.sv
      - hw/vec_scale.sv
      - hw/vec_clamp_one.sv
      - hw/fp_to_int.sv
      - hw/pixel_shader.sv
      - hw/pixel_rgb_formatter.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/pixel_rgb_formatter_props.sv
      - dv/pixel_rgb_formatter_tb.sv
